// File: mipsCtrl_macros.svh
`ifndef MIPSCTRL_MACROS_SVH
`define MIPSCTRL_MACROS_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6
`define SHAMT_W 5

`define STATE_W 5

`define OP_RTYPE 6'h00
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_LW 6'h23
`define OP_SW 6'h2b
`define OP_LUI 6'h0f
`define OP_J 6'h02
`define OP_JAL 6'h03

// funct codes, R-type only
`define FN_ADD 6'h20
`define FN_AND 6'h24
`define FN_SUB 6'h22
`define FN_XOR 6'h26
`define FN_BREAK 6'h0d
`define FN_JR 6'h08
`define FN_NOP 6'h00

`endif

// File: mipsCtrlPkg.sv
`default_nettype none

`include "mipsCtrl_macros.svh"

package mipsCtrlPkg;

	typedef enum logic [`STATE_W-1:0] {
		Reset, MemoryRead, WaitMemoryRead, IRWrite, Decode, // fetch chain
		Add, And, Sub, Xor,
		Break, Nop, WriteRegAlu,
		Beq, Bne,
		Lw, LwAddr, LwWait, LwCapture, LwWrite,
		Sw, SwWrite, SwWait,
		Lui, J, Jr, JalLink, Jal
	} stateT;

	typedef enum logic [3:0] {
		ClsAdd, ClsAnd, ClsSub, ClsXor,
		ClsBreak, ClsNop, ClsJr,
		ClsBeq, ClsBne, ClsLw, ClsSw,
		ClsLui, ClsJ, ClsJal,
		ClsIllegal
	} instrClassT;

	// encodings match the ALU in the datapath
	typedef enum logic [2:0] {
		AluAnd = 3'd0,
		AluAdd = 3'd1,
		AluSub = 3'd2,
		AluAndR = 3'd3,
		AluXor = 3'd6
	} aluOpT;

	typedef enum logic [1:0] {PcAlu, PcBranch, PcJump, PcReg} pcSrcT;

	typedef enum logic [1:0] {DstRt, DstRd, DstRa} regDstT;

	typedef enum logic [2:0] {
		FromAlu = 3'd0,
		FromMem = 3'd1,
		FromUpperImm = 3'd2,
		FromLink = 3'd6 // pc + 4 for jal
	} memToRegT;

	typedef enum logic [1:0] {SrcBReg, SrcBFour, SrcBImm, SrcBBranchOff} aluSrcBT;

endpackage

`default_nettype wire

// File: instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCtrl_macros.svh"

module instrDecoder (
	input logic [`OPCODE_W-1:0] opcode,
	input logic [`FUNCT_W-1:0] funct,
	input logic [`SHAMT_W-1:0] shamt,
	output mipsCtrlPkg::instrClassT instrClass
);

	import mipsCtrlPkg::*;

	always_comb
	begin
		instrClass = ClsIllegal;
		case (opcode)
			`OP_RTYPE:
			begin
				case (funct)
					`FN_ADD: instrClass = ClsAdd;
					`FN_AND: instrClass = ClsAnd;
					`FN_SUB: instrClass = ClsSub;
					`FN_XOR: instrClass = ClsXor;
					`FN_BREAK: instrClass = ClsBreak;
					`FN_JR: instrClass = ClsJr;
					`FN_NOP:
					begin
						// shifts are gone, so any shamt other than zero is illegal
						if (shamt == '0)
							instrClass = ClsNop;
						else
							instrClass = ClsIllegal;
					end
					default: instrClass = ClsIllegal;
				endcase
			end
			`OP_BEQ: instrClass = ClsBeq;
			`OP_BNE: instrClass = ClsBne;
			`OP_LW: instrClass = ClsLw;
			`OP_SW: instrClass = ClsSw;
			`OP_LUI: instrClass = ClsLui;
			`OP_J: instrClass = ClsJ;
			`OP_JAL: instrClass = ClsJal;
			default: instrClass = ClsIllegal;
		endcase
	end

endmodule

`default_nettype wire

// File: controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
	input logic clk,
	input logic reset,
	input mipsCtrlPkg::instrClassT instrClass,
	output mipsCtrlPkg::stateT state
);

	import mipsCtrlPkg::*;

	stateT nextState;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= Reset;
		else
			state <= nextState;
	end

	always_comb
	begin
		case (state)
			Reset: nextState = MemoryRead;
			MemoryRead: nextState = WaitMemoryRead;
			WaitMemoryRead: nextState = IRWrite;
			IRWrite: nextState = Decode;
			Decode:
			begin
				case (instrClass) // fields only matter here
					ClsAdd: nextState = Add;
					ClsAnd: nextState = And;
					ClsSub: nextState = Sub;
					ClsXor: nextState = Xor;
					ClsNop: nextState = Nop;
					ClsJr: nextState = Jr;
					ClsBeq: nextState = Beq;
					ClsBne: nextState = Bne;
					ClsLw: nextState = Lw;
					ClsSw: nextState = Sw;
					ClsLui: nextState = Lui;
					ClsJ: nextState = J;
					ClsJal: nextState = JalLink;
					default: nextState = Break; // break and illegal
				endcase
			end
			Add, And, Sub, Xor: nextState = WriteRegAlu;
			Break: nextState = Break; // halted until reset
			Lw: nextState = LwAddr;
			LwAddr: nextState = LwWait;
			LwWait: nextState = LwCapture;
			LwCapture: nextState = LwWrite;
			Sw: nextState = SwWrite;
			SwWrite: nextState = SwWait;
			JalLink: nextState = Jal;
			Nop, WriteRegAlu, Beq, Bne, LwWrite, SwWait, Lui, J, Jr, Jal:
				nextState = MemoryRead;
			default: nextState = Reset; // unused encodings
		endcase
	end

	stateKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(state))
		else $error("state register unknown");

	breakHolds: assert property (@(posedge clk) disable iff (reset)
		state == Break |=> state == Break)
		else $error("left Break without reset");

endmodule

`default_nettype wire

// File: strobeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module strobeDecoder (
	input mipsCtrlPkg::stateT state,
	output logic memWriteOrRead,
	output logic mdrControl,
	output logic pcControl,
	output logic pcCond,
	output logic bneOrBeq,
	output logic irWrite,
	output logic writeA,
	output logic writeB,
	output logic regWrite,
	output logic aluSrcA,
	output logic regAluControl,
	output logic iOrD,
	output mipsCtrlPkg::pcSrcT origPC,
	output mipsCtrlPkg::aluSrcBT aluSrcB,
	output mipsCtrlPkg::aluOpT aluControl,
	output mipsCtrlPkg::regDstT regDst,
	output mipsCtrlPkg::memToRegT memToReg
);

	import mipsCtrlPkg::*;

	always_comb
	begin
		memWriteOrRead = 1'b0;
		mdrControl = 1'b0;
		pcControl = 1'b0;
		pcCond = 1'b0;
		bneOrBeq = 1'b0;
		irWrite = 1'b0;
		writeA = 1'b0;
		writeB = 1'b0;
		regWrite = 1'b0;
		aluSrcA = 1'b0;
		regAluControl = 1'b0;
		iOrD = 1'b0;
		origPC = PcAlu;
		aluSrcB = SrcBReg;
		aluControl = AluAnd;
		regDst = DstRt;
		memToReg = FromAlu;

		case (state)
			Reset:
				irWrite = 1'b1;
			MemoryRead, WaitMemoryRead:
			begin
				irWrite = 1'b1;
				aluSrcB = SrcBFour; // pc + 4
				aluControl = AluAdd;
			end
			IRWrite:
			begin
				irWrite = 1'b1;
				aluSrcB = SrcBFour;
				aluControl = AluAdd;
				pcControl = 1'b1;
				origPC = PcAlu;
			end
			Decode:
			begin
				writeA = 1'b1;
				writeB = 1'b1;
				aluSrcB = SrcBBranchOff; // branch target precomputed
				aluControl = AluAdd;
				regAluControl = 1'b1;
			end
			Add, And, Sub, Xor:
			begin
				aluSrcA = 1'b1;
				regAluControl = 1'b1;
				case (state)
					And: aluControl = AluAndR;
					Sub: aluControl = AluSub;
					Xor: aluControl = AluXor;
					default: aluControl = AluAdd;
				endcase
			end
			WriteRegAlu:
			begin
				regWrite = 1'b1;
				regDst = DstRd;
				memToReg = FromAlu;
			end
			Beq, Bne:
			begin
				aluSrcA = 1'b1;
				aluControl = AluSub; // compare rs and rt
				pcCond = 1'b1;
				origPC = PcBranch;
				bneOrBeq = (state == Beq);
			end
			Lw, Sw:
			begin
				aluSrcA = 1'b1;
				aluSrcB = SrcBImm;
				aluControl = AluAdd;
				regAluControl = 1'b1;
			end
			LwAddr, LwWait:
				iOrD = 1'b1;
			LwCapture:
			begin
				iOrD = 1'b1;
				mdrControl = 1'b1;
			end
			LwWrite:
			begin
				regWrite = 1'b1;
				regDst = DstRt;
				memToReg = FromMem;
			end
			SwWrite, SwWait:
			begin
				iOrD = 1'b1;
				memWriteOrRead = 1'b1;
			end
			Lui:
			begin
				regWrite = 1'b1;
				memToReg = FromUpperImm;
			end
			J, Jal:
			begin
				pcControl = 1'b1;
				origPC = PcJump;
			end
			Jr:
			begin
				pcControl = 1'b1;
				origPC = PcReg;
			end
			JalLink:
			begin
				regWrite = 1'b1;
				regDst = DstRa; // r31
				memToReg = FromLink;
			end
			default:
			begin
			end
		endcase
	end

	noWriteClash: assert property (@(state) !(regWrite && memWriteOrRead))
		else $error("register write and memory write in the same state");

	condUsesBranch: assert property (@(state) pcCond |-> origPC == PcBranch)
		else $error("conditional pc load without branch target");

endmodule

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCtrl_macros.svh"

module controlUnit (
	input logic clk,
	input logic reset,
	input logic [`OPCODE_W-1:0] opcode,
	input logic [`FUNCT_W-1:0] funct,
	input logic [`SHAMT_W-1:0] shamt,
	output logic memWriteOrRead,
	output logic mdrControl,
	output logic pcControl,
	output logic pcCond,
	output logic bneOrBeq,
	output logic irWrite,
	output logic writeA,
	output logic writeB,
	output logic regWrite,
	output logic aluSrcA,
	output logic regAluControl,
	output logic iOrD,
	output mipsCtrlPkg::pcSrcT origPC,
	output mipsCtrlPkg::aluSrcBT aluSrcB,
	output mipsCtrlPkg::aluOpT aluControl,
	output mipsCtrlPkg::regDstT regDst,
	output mipsCtrlPkg::memToRegT memToReg,
	output mipsCtrlPkg::stateT stateOut
);

	mipsCtrlPkg::instrClassT instrClass;

	instrDecoder u_instrDecoder (
		.opcode(opcode),
		.funct(funct),
		.shamt(shamt),
		.instrClass(instrClass)
	);

	controlSequencer u_controlSequencer (
		.clk(clk),
		.reset(reset),
		.instrClass(instrClass),
		.state(stateOut) // also the debug port
	);

	strobeDecoder u_strobeDecoder (
		.state(stateOut),
		.memWriteOrRead(memWriteOrRead),
		.mdrControl(mdrControl),
		.pcControl(pcControl),
		.pcCond(pcCond),
		.bneOrBeq(bneOrBeq),
		.irWrite(irWrite),
		.writeA(writeA),
		.writeB(writeB),
		.regWrite(regWrite),
		.aluSrcA(aluSrcA),
		.regAluControl(regAluControl),
		.iOrD(iOrD),
		.origPC(origPC),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.regDst(regDst),
		.memToReg(memToReg)
	);

endmodule

`default_nettype wire

// File: controlChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCtrl_macros.svh"

module controlChecker (
	input logic clk,
	input logic reset,
	input logic [`OPCODE_W-1:0] opcode,
	input logic [`FUNCT_W-1:0] funct,
	input logic [`SHAMT_W-1:0] shamt,
	input mipsCtrlPkg::instrClassT intendedClass,
	input mipsCtrlPkg::stateT stateOut,
	input logic regWrite,
	input logic memWriteOrRead,
	input logic pcControl,
	input logic pcCond,
	input logic bneOrBeq,
	input logic mdrControl,
	input logic irWrite,
	input logic writeA,
	input logic writeB,
	input logic aluSrcA,
	input logic regAluControl,
	input logic iOrD,
	input mipsCtrlPkg::pcSrcT origPC,
	input mipsCtrlPkg::aluSrcBT aluSrcB,
	input mipsCtrlPkg::aluOpT aluControl,
	input mipsCtrlPkg::regDstT regDst,
	input mipsCtrlPkg::memToRegT memToReg,
	output int errorCount,
	output int testsDone
);

	import mipsCtrlPkg::*;

	typedef struct packed {
		stateT st;
		logic regWrite;
		logic memWrite;
		logic pcControl;
		logic pcCond;
		logic bneOrBeq;
		logic mdrControl;
		logic irWrite;
		logic writeA;
		logic writeB;
		logic aluSrcA;
		logic regAluControl;
		logic iOrD;
		pcSrcT origPC;
		aluSrcBT aluSrcB;
		regDstT regDst;
		memToRegT memToReg;
		aluOpT alu;
		logic careDst;
		logic careAlu;
	} expectT;

	instrClassT cls = ClsNop;
	int step = 0;
	int testErrors = 0;
	logic awaitingReset = 1'b1;
	logic testOpen = 1'b0;
	logic [`OPCODE_W-1:0] seenOp = '0;
	logic [`FUNCT_W-1:0] seenFn = '0;
	logic [`SHAMT_W-1:0] seenSh = '0;

	initial
	begin
		errorCount = 0;
		testsDone = 0;
	end

	// cycles from MemoryRead to the next MemoryRead
	function automatic int classLength(input instrClassT c);
		case (c)
			ClsAdd, ClsAnd, ClsSub, ClsXor, ClsJal: return 6;
			ClsLw: return 9;
			ClsSw: return 7;
			ClsBreak, ClsIllegal: return 0; // never back to fetch
			default: return 5;
		endcase
	endfunction

	function automatic expectT expectedAt(input instrClassT c, input int step);
		expectT e;
		int k;
		e = '0;
		k = step - 4; // index into the execute chain
		case (step)
			0, 1, 2:
			begin
				e.st = (step == 0) ? MemoryRead : (step == 1) ? WaitMemoryRead : IRWrite;
				e.irWrite = 1'b1;
				e.aluSrcB = SrcBFour; // pc + 4 during fetch
				e.careAlu = 1'b1;
				e.alu = AluAdd;
				e.pcControl = (step == 2);
				e.origPC = PcAlu;
			end
			3:
			begin
				e.st = Decode;
				e.writeA = 1'b1;
				e.writeB = 1'b1;
				e.regAluControl = 1'b1;
				e.aluSrcB = SrcBBranchOff;
				e.careAlu = 1'b1;
				e.alu = AluAdd;
			end
			default:
			case (c)
				ClsAdd, ClsAnd, ClsSub, ClsXor:
				begin
					if (k == 0)
					begin
						e.careAlu = 1'b1;
						e.aluSrcA = 1'b1;
						e.regAluControl = 1'b1;
						e.st = (c == ClsAdd) ? Add : (c == ClsAnd) ? And : (c == ClsSub) ? Sub : Xor;
						e.alu = (c == ClsAdd) ? AluAdd : (c == ClsAnd) ? AluAndR :
							(c == ClsSub) ? AluSub : AluXor;
					end
					else
					begin
						e.st = WriteRegAlu;
						e.regWrite = 1'b1;
						e.careDst = 1'b1;
						e.regDst = DstRd;
						e.memToReg = FromAlu;
					end
				end
				ClsBeq, ClsBne:
				begin
					e.st = (c == ClsBeq) ? Beq : Bne;
					e.pcCond = 1'b1;
					e.origPC = PcBranch;
					e.aluSrcA = 1'b1;
					e.careAlu = 1'b1;
					e.alu = AluSub;
					e.bneOrBeq = (c == ClsBeq);
				end
				ClsLw:
				begin
					e.st = (k == 0) ? Lw : (k == 1) ? LwAddr : (k == 2) ? LwWait :
						(k == 3) ? LwCapture : LwWrite;
					e.mdrControl = (k == 3);
					e.iOrD = (k >= 1 && k <= 3);
					if (k == 0)
					begin
						e.aluSrcA = 1'b1;
						e.aluSrcB = SrcBImm; // base plus offset
						e.regAluControl = 1'b1;
						e.careAlu = 1'b1;
						e.alu = AluAdd;
					end
					if (k == 4)
					begin
						e.regWrite = 1'b1;
						e.careDst = 1'b1;
						e.regDst = DstRt;
						e.memToReg = FromMem;
					end
				end
				ClsSw:
				begin
					e.st = (k == 0) ? Sw : (k == 1) ? SwWrite : SwWait;
					e.memWrite = (k != 0);
					e.iOrD = (k != 0);
					if (k == 0)
					begin
						e.aluSrcA = 1'b1;
						e.aluSrcB = SrcBImm;
						e.regAluControl = 1'b1;
						e.careAlu = 1'b1;
						e.alu = AluAdd;
					end
				end
				ClsLui:
				begin
					e.st = Lui;
					e.regWrite = 1'b1;
					e.memToReg = FromUpperImm;
				end
				ClsJ, ClsJr:
				begin
					e.st = (c == ClsJ) ? J : Jr;
					e.pcControl = 1'b1;
					e.origPC = (c == ClsJ) ? PcJump : PcReg;
				end
				ClsJal:
				begin
					if (k == 0)
					begin
						e.st = JalLink;
						e.regWrite = 1'b1;
						e.careDst = 1'b1;
						e.regDst = DstRa;
						e.memToReg = FromLink;
					end
					else
					begin
						e.st = Jal;
						e.pcControl = 1'b1;
						e.origPC = PcJump;
					end
				end
				ClsNop: e.st = Nop;
				default: e.st = Break;
			endcase
		endcase
		return e;
	endfunction

	task automatic checkValue(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (expected !== actual)
		begin
			$display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("ERROR %s at %0t", what, $time);
		errorCount++;
		testErrors++;
	endtask

	task automatic compareOutputs(input expectT e);
		checkValue("stateOut", e.st, stateOut);
		checkValue("regWrite", e.regWrite, regWrite);
		checkValue("memWriteOrRead", e.memWrite, memWriteOrRead);
		checkValue("pcControl", e.pcControl, pcControl);
		checkValue("pcCond", e.pcCond, pcCond);
		checkValue("bneOrBeq", e.bneOrBeq, bneOrBeq);
		checkValue("mdrControl", e.mdrControl, mdrControl);
		checkValue("irWrite", e.irWrite, irWrite);
		checkValue("writeA", e.writeA, writeA);
		checkValue("writeB", e.writeB, writeB);
		checkValue("aluSrcA", e.aluSrcA, aluSrcA);
		checkValue("regAluControl", e.regAluControl, regAluControl);
		checkValue("iOrD", e.iOrD, iOrD);
		checkValue("aluSrcB", e.aluSrcB, aluSrcB);
		if (e.pcControl || e.pcCond)
			checkValue("origPC", e.origPC, origPC);
		if (e.regWrite)
			checkValue("memToReg", e.memToReg, memToReg);
		if (e.careDst)
			checkValue("regDst", e.regDst, regDst);
		if (e.careAlu)
			checkValue("aluControl", e.alu, aluControl);
	endtask

	task automatic closeTest();
		testsDone++;
		$display("test %0d %s op=%h funct=%h shamt=%h: %s", testsDone, cls.name(),
			seenOp, seenFn, seenSh, (testErrors == 0) ? "pass" : "fail");
		testOpen = 1'b0;
	endtask

	task automatic printTotals();
		$display("tests run %0d, errors %0d", testsDone, errorCount);
	endtask

	always @(negedge clk)
	begin
		if (reset !== 1'b0)
		begin
			if (testOpen)
				closeTest();
			awaitingReset = 1'b1;
		end
		else if (awaitingReset)
		begin
			checkValue("stateOut", Reset, stateOut); // single Reset cycle after release
			checkValue("regWrite", 1'b0, regWrite);
			checkValue("memWriteOrRead", 1'b0, memWriteOrRead);
			checkValue("pcControl", 1'b0, pcControl);
			checkValue("pcCond", 1'b0, pcCond);
			checkValue("mdrControl", 1'b0, mdrControl);
			checkValue("irWrite", 1'b1, irWrite);
			awaitingReset = 1'b0;
			step = 0;
		end
		else
		begin
			if (step == 0)
			begin
				testOpen = 1'b1;
				testErrors = 0;
			end
			if (step == 3)
			begin
				cls = intendedClass; // fields are stable by Decode
				seenOp = opcode;
				seenFn = funct;
				seenSh = shamt;
			end
			if (step == 0 && stateOut != MemoryRead)
				reportFailure("machine did not return to MemoryRead");
			else
				compareOutputs(expectedAt(cls, step));
			step++;
			if (step == classLength(cls))
			begin
				closeTest();
				step = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCtrl_macros.svh"

module tb_controlUnit;

	import mipsCtrlPkg::*;

	logic clk;
	logic reset;
	logic [`OPCODE_W-1:0] opcode;
	logic [`FUNCT_W-1:0] funct;
	logic [`SHAMT_W-1:0] shamt;
	logic memWriteOrRead, mdrControl, pcControl, pcCond, bneOrBeq, irWrite;
	logic writeA, writeB, regWrite, aluSrcA, regAluControl, iOrD;
	pcSrcT origPC;
	aluSrcBT aluSrcB;
	aluOpT aluControl;
	regDstT regDst;
	memToRegT memToReg;
	stateT stateOut;
	instrClassT intendedClass;
	int errorCount;
	int testsDone;

	logic [31:0] lfsr;
	int timeoutLimit;
	int cycleCount;
	instrClassT progCls[$];
	logic [`OPCODE_W-1:0] progOp[$];
	logic [`FUNCT_W-1:0] progFn[$];
	logic [`SHAMT_W-1:0] progSh[$];

	controlUnit u_dut (.*);

	controlChecker u_checker (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[31]};
		end
	endtask

	task automatic pushInstr(input instrClassT c, input logic [`OPCODE_W-1:0] op,
		input logic [`FUNCT_W-1:0] fn, input logic [`SHAMT_W-1:0] sh);
		progCls.push_back(c);
		progOp.push_back(op);
		progFn.push_back(fn);
		progSh.push_back(sh);
	endtask

	task automatic addInstr(input instrClassT c);
		logic [31:0] r;
		logic [`OPCODE_W-1:0] op;
		logic [`FUNCT_W-1:0] fn;
		logic [`SHAMT_W-1:0] sh;
		drawBits(11, r);
		op = `OP_RTYPE;
		fn = r[5:0]; // don't care outside R-type
		sh = r[10:6];
		case (c)
			ClsAdd: fn = `FN_ADD;
			ClsAnd: fn = `FN_AND;
			ClsSub: fn = `FN_SUB;
			ClsXor: fn = `FN_XOR;
			ClsBreak: fn = `FN_BREAK;
			ClsJr: fn = `FN_JR;
			ClsNop:
			begin
				fn = `FN_NOP;
				sh = '0;
			end
			ClsBeq: op = `OP_BEQ;
			ClsBne: op = `OP_BNE;
			ClsLw: op = `OP_LW;
			ClsSw: op = `OP_SW;
			ClsLui: op = `OP_LUI;
			ClsJ: op = `OP_J;
			ClsJal: op = `OP_JAL;
			default: op = {2'b11, r[3:0]}; // 0x30 and up are unlisted
		endcase
		pushInstr(c, op, fn, sh);
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		for (int c = 0; c <= ClsJal; c++)
		begin
			if (instrClassT'(c) != ClsBreak)
				addInstr(instrClassT'(c));
		end
		repeat (12)
		begin
			do
			begin
				drawBits(4, r);
			end
			while (r[3:0] > ClsJal || r[3:0] == ClsBreak);
			addInstr(instrClassT'(r[3:0]));
		end
		addInstr(ClsBreak); // halting cases last
		addInstr(ClsIllegal);
		drawBits(5, r);
		pushInstr(ClsIllegal, `OP_RTYPE, `FN_NOP, r[4:0] | 5'h01); // nop with shamt
	endtask

	task automatic waitFetch();
		do
		begin
			@(negedge clk);
		end
		while (stateOut != MemoryRead);
	endtask

	task automatic runInstr(input int i);
		waitFetch();
		@(posedge clk);
		opcode <= progOp[i];
		funct <= progFn[i];
		shamt <= progSh[i];
		intendedClass <= progCls[i];
		if (progCls[i] == ClsBreak || progCls[i] == ClsIllegal)
		begin
			do
			begin
				@(negedge clk);
			end
			while (stateOut != Break);
			repeat (4) @(negedge clk); // should stay halted
			@(posedge clk);
			reset <= 1'b1;
			repeat (3) @(posedge clk);
			reset <= 1'b0;
		end
	endtask

	initial
	begin
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		shamt = '0;
		intendedClass = ClsNop;
		lfsr = 32'h66b9dbd0;
		buildProgram();
		timeoutLimit = 4 + 50;
		foreach (progCls[i])
		begin
			if (progCls[i] == ClsBreak || progCls[i] == ClsIllegal)
				timeoutLimit += 14; // fetch, hold, reset
			else
				timeoutLimit += u_checker.classLength(progCls[i]);
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		foreach (progCls[i])
			runInstr(i);
		waitFetch();
		u_checker.printTotals();
		if (errorCount == 0 && testsDone == progCls.size())
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial
	begin
		cycleCount = 0;
		@(posedge clk);
		while (cycleCount < timeoutLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout, the run did not finish within %0d cycles", cycleCount);
		u_checker.printTotals();
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
mipsCtrlPkg.sv
instrDecoder.sv
controlSequencer.sv
strobeDecoder.sv
controlUnit.sv
controlChecker.sv
tb_controlUnit.sv
